//--- include/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// word and address widths
`define MEM_DATA_W  16
`define MEM_ADDR_W  16

// 16 lines per cache, tag is whatever address is left above the index
`define MEM_INDEX_W 4

// cycles from an accepted request to ack, 2 or more
`define MEM_LATENCY 4

`endif

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

   // cache miss FSM
   typedef enum {
      CACHE_IDLE,
      CACHE_REQUEST,   // req high, waiting for ack
      CACHE_RELEASE,   // req low, waiting for ack to drop
      CACHE_FILL       // update the line, then back to idle
   } cache_state_t;

   // who owns the memory port
   typedef enum {
      ARB_IDLE,
      ARB_I_GRANT,
      ARB_D_GRANT
   } arb_state_t;

   // backing memory sequencing
   typedef enum {
      MEM_IDLE,
      MEM_BUSY,        // counting latency
      MEM_ACK          // ack held until req drops
   } mem_state_t;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_t;

endpackage

`default_nettype wire

//--- logic/icache.sv
`default_nettype none

`include "mem_defs.svh"

module icache (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_fetch_en,
   input  wire [`MEM_ADDR_W-1:0]  i_fetch_addr,
   output logic [`MEM_DATA_W-1:0] o_instr,
   output logic                   o_i_busy,
   output logic                   o_mem_req,
   output logic [`MEM_ADDR_W-1:0] o_mem_addr,
   input  wire                    i_mem_ack,
   input  wire [`MEM_DATA_W-1:0]  i_mem_rdata
);
   import mem_pkg::*;

   localparam int TAG_W = `MEM_ADDR_W - `MEM_INDEX_W;
   localparam int LINES = 1 << `MEM_INDEX_W;

   cache_state_t state_q;

   logic [LINES-1:0]        valid_q;
   logic [TAG_W-1:0]        tag_array [LINES];
   logic [`MEM_DATA_W-1:0]  data_array [LINES];

   logic [`MEM_INDEX_W-1:0] index;
   logic [TAG_W-1:0]        tag;
   logic                    hit;

   logic [`MEM_ADDR_W-1:0]  miss_addr_q;   // line being fetched
   logic [`MEM_DATA_W-1:0]  fill_data_q;
   logic [`MEM_INDEX_W-1:0] fill_index;

   // lookup straight off the processor address
   assign index = i_fetch_addr[`MEM_INDEX_W-1:0];
   assign tag   = i_fetch_addr[`MEM_ADDR_W-1:`MEM_INDEX_W];
   assign hit   = valid_q[index] && (tag_array[index] == tag);

   assign o_instr  = data_array[index];
   assign o_i_busy = i_fetch_en && ((state_q != CACHE_IDLE) || !hit);

   assign o_mem_req  = (state_q == CACHE_REQUEST);
   assign o_mem_addr = miss_addr_q;
   assign fill_index = miss_addr_q[`MEM_INDEX_W-1:0];

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= CACHE_IDLE;
      end else begin
         case (state_q)
            CACHE_IDLE: begin
               if (i_fetch_en && !hit) begin
                  state_q <= CACHE_REQUEST;
               end
            end
            CACHE_REQUEST: begin
               if (i_mem_ack) begin
                  state_q <= CACHE_RELEASE;
               end
            end
            CACHE_RELEASE: begin
               if (!i_mem_ack) begin
                  state_q <= CACHE_FILL;
               end
            end
            default: state_q <= CACHE_IDLE;   // fill lasts one cycle
         endcase
      end
   end

   // miss address and returned word
   always_ff @(posedge clk) begin
      if (state_q == CACHE_IDLE) begin
         miss_addr_q <= i_fetch_addr;
      end
      if (state_q == CACHE_REQUEST && i_mem_ack) begin
         fill_data_q <= i_mem_rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         valid_q <= '0;
      end else if (state_q == CACHE_FILL) begin
         valid_q[fill_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == CACHE_FILL) begin
         tag_array[fill_index]  <= miss_addr_q[`MEM_ADDR_W-1:`MEM_INDEX_W];
         data_array[fill_index] <= fill_data_q;
      end
   end

endmodule

`default_nettype wire

//--- logic/dcache.sv
`default_nettype none

`include "mem_defs.svh"

module dcache (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_d_rd_en,
   input  wire                    i_d_wr_en,
   input  wire [`MEM_ADDR_W-1:0]  i_d_addr,
   input  wire [`MEM_DATA_W-1:0]  i_d_wdata,
   output logic [`MEM_DATA_W-1:0] o_d_rdata,
   output logic                   o_d_busy,
   output logic                   o_mem_req,
   output mem_pkg::mem_op_t       o_mem_op,
   output logic [`MEM_ADDR_W-1:0] o_mem_addr,
   output logic [`MEM_DATA_W-1:0] o_mem_wdata,
   input  wire                    i_mem_ack,
   input  wire [`MEM_DATA_W-1:0]  i_mem_rdata
);
   import mem_pkg::*;

   localparam int TAG_W = `MEM_ADDR_W - `MEM_INDEX_W;
   localparam int LINES = 1 << `MEM_INDEX_W;

   cache_state_t state_q;

   logic [LINES-1:0]        valid_q;
   logic [TAG_W-1:0]        tag_array [LINES];
   logic [`MEM_DATA_W-1:0]  data_array [LINES];

   logic [`MEM_INDEX_W-1:0] index;
   logic [TAG_W-1:0]        tag;
   logic                    hit;
   logic                    access;

   // captured access, held for the whole transfer
   mem_op_t                 op_q;
   logic [`MEM_ADDR_W-1:0]  addr_q;
   logic [`MEM_DATA_W-1:0]  wdata_q;
   logic [`MEM_DATA_W-1:0]  fill_data_q;
   logic [`MEM_INDEX_W-1:0] fill_index;
   logic [TAG_W-1:0]        fill_tag;
   logic                    fill_hit;

   assign index  = i_d_addr[`MEM_INDEX_W-1:0];
   assign tag    = i_d_addr[`MEM_ADDR_W-1:`MEM_INDEX_W];
   assign hit    = valid_q[index] && (tag_array[index] == tag);
   assign access = i_d_rd_en || i_d_wr_en;

   assign fill_index = addr_q[`MEM_INDEX_W-1:0];
   assign fill_tag   = addr_q[`MEM_ADDR_W-1:`MEM_INDEX_W];
   assign fill_hit   = valid_q[fill_index] && (tag_array[fill_index] == fill_tag);

   assign o_d_rdata   = data_array[index];
   assign o_mem_req   = (state_q == CACHE_REQUEST);
   assign o_mem_op    = op_q;
   assign o_mem_addr  = addr_q;
   assign o_mem_wdata = wdata_q;

   // a write finishes in fill, a read finishes on the hit that follows
   always_comb begin
      case (state_q)
         CACHE_IDLE: o_d_busy = i_d_wr_en || (i_d_rd_en && !hit);
         CACHE_FILL: o_d_busy = access && (op_q == MEM_READ);
         default:    o_d_busy = access;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= CACHE_IDLE;
      end else begin
         case (state_q)
            CACHE_IDLE: begin
               if (i_d_wr_en || (i_d_rd_en && !hit)) begin
                  state_q <= CACHE_REQUEST;
               end
            end
            CACHE_REQUEST: begin
               if (i_mem_ack) begin
                  state_q <= CACHE_RELEASE;
               end
            end
            CACHE_RELEASE: begin
               if (!i_mem_ack) begin
                  state_q <= CACHE_FILL;
               end
            end
            default: state_q <= CACHE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == CACHE_IDLE) begin
         op_q    <= i_d_wr_en ? MEM_WRITE : MEM_READ;
         addr_q  <= i_d_addr;
         wdata_q <= i_d_wdata;
      end
      if (state_q == CACHE_REQUEST && i_mem_ack) begin
         fill_data_q <= i_mem_rdata;   // don't care on writes
      end
   end

   // no allocate on write miss
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         valid_q <= '0;
      end else if (state_q == CACHE_FILL && op_q == MEM_READ) begin
         valid_q[fill_index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == CACHE_FILL) begin
         if (op_q == MEM_READ) begin
            tag_array[fill_index]  <= fill_tag;
            data_array[fill_index] <= fill_data_q;
         end else if (fill_hit) begin
            data_array[fill_index] <= wdata_q;   // keep a write hit coherent
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/mem_arbiter.sv
`default_nettype none

`include "mem_defs.svh"

module mem_arbiter (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_i_req,
   input  wire [`MEM_ADDR_W-1:0]  i_i_addr,
   output logic                   o_i_ack,
   input  wire                    i_d_req,
   input  mem_pkg::mem_op_t       i_d_op,
   input  wire [`MEM_ADDR_W-1:0]  i_d_addr,
   input  wire [`MEM_DATA_W-1:0]  i_d_wdata,
   output logic                   o_d_ack,
   output logic [`MEM_DATA_W-1:0] o_rdata,
   output logic                   o_mem_req,
   output mem_pkg::mem_op_t       o_mem_op,
   output logic [`MEM_ADDR_W-1:0] o_mem_addr,
   output logic [`MEM_DATA_W-1:0] o_mem_wdata,
   input  wire                    i_mem_ack,
   input  wire [`MEM_DATA_W-1:0]  i_mem_rdata
);
   import mem_pkg::*;

   arb_state_t state_q;

   // grant is registered, so a new owner is seen one cycle after its req
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= ARB_IDLE;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (i_i_req) begin
                  state_q <= ARB_I_GRANT;   // instruction side first
               end else if (i_d_req) begin
                  state_q <= ARB_D_GRANT;
               end
            end
            ARB_I_GRANT: begin
               if (!i_i_req && !i_mem_ack) begin
                  state_q <= ARB_IDLE;
               end
            end
            default: begin
               if (!i_d_req && !i_mem_ack) begin
                  state_q <= ARB_IDLE;
               end
            end
         endcase
      end
   end

   // forward the owner's channel
   always_comb begin
      o_mem_req   = 1'b0;
      o_mem_op    = MEM_READ;
      o_mem_addr  = i_i_addr;
      o_mem_wdata = '0;
      case (state_q)
         ARB_I_GRANT: o_mem_req = i_i_req;   // icache only reads
         ARB_D_GRANT: begin
            o_mem_req   = i_d_req;
            o_mem_op    = i_d_op;
            o_mem_addr  = i_d_addr;
            o_mem_wdata = i_d_wdata;
         end
         default: o_mem_req = 1'b0;
      endcase
   end

   assign o_i_ack = (state_q == ARB_I_GRANT) && i_mem_ack;
   assign o_d_ack = (state_q == ARB_D_GRANT) && i_mem_ack;
   assign o_rdata = i_mem_rdata;   // shared, qualified by ack

endmodule

`default_nettype wire

//--- logic/multicycle_memory.sv
`default_nettype none

`include "mem_defs.svh"

module multicycle_memory (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_mem_req,
   input  mem_pkg::mem_op_t       i_mem_op,
   input  wire [`MEM_ADDR_W-1:0]  i_mem_addr,
   input  wire [`MEM_DATA_W-1:0]  i_mem_wdata,
   output logic                   o_mem_ack,
   output logic [`MEM_DATA_W-1:0] o_mem_rdata
);
   import mem_pkg::*;

   localparam int DEPTH = 1 << `MEM_ADDR_W;
   localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

   mem_state_t state_q;
   logic [CNT_W-1:0] cnt_q;
   logic last;   // final latency cycle, op happens here

   logic [`MEM_DATA_W-1:0] mem_array [DEPTH];

   mem_op_t                op_q;
   logic [`MEM_ADDR_W-1:0] addr_q;
   logic [`MEM_DATA_W-1:0] wdata_q;

   // cnt is 1 after the edge that first sees req
   assign last      = (state_q == MEM_BUSY) && (cnt_q == CNT_W'(`MEM_LATENCY - 1));
   assign o_mem_ack = (state_q == MEM_ACK);

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state_q <= MEM_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            MEM_IDLE: begin
               if (i_mem_req) begin
                  state_q <= MEM_BUSY;
                  cnt_q   <= CNT_W'(1);
               end
            end
            MEM_BUSY: begin
               if (last) begin
                  state_q <= MEM_ACK;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               if (!i_mem_req) begin
                  state_q <= MEM_IDLE;   // ack drops next edge
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == MEM_IDLE && i_mem_req) begin
         op_q    <= i_mem_op;
         addr_q  <= i_mem_addr;
         wdata_q <= i_mem_wdata;
      end
      if (last) begin
         if (op_q == MEM_WRITE) begin
            mem_array[addr_q] <= wdata_q;
         end else begin
            o_mem_rdata <= mem_array[addr_q];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/memory.sv
`default_nettype none

`include "mem_defs.svh"

module memory (
   input  wire                    clk,
   input  wire                    i_rst_n,
   input  wire                    i_fetch_en,
   input  wire [`MEM_ADDR_W-1:0]  i_fetch_addr,
   output logic [`MEM_DATA_W-1:0] o_instr,
   output logic                   o_i_busy,
   input  wire                    i_d_rd_en,
   input  wire                    i_d_wr_en,
   input  wire [`MEM_ADDR_W-1:0]  i_d_addr,
   input  wire [`MEM_DATA_W-1:0]  i_d_wdata,
   output logic [`MEM_DATA_W-1:0] o_d_rdata,
   output logic                   o_d_busy
);
   import mem_pkg::*;

   // icache to arbiter
   logic                   i_mem_req;
   logic [`MEM_ADDR_W-1:0] i_mem_addr;
   logic                   i_mem_ack;

   // dcache to arbiter
   logic                   d_mem_req;
   mem_op_t                d_mem_op;
   logic [`MEM_ADDR_W-1:0] d_mem_addr;
   logic [`MEM_DATA_W-1:0] d_mem_wdata;
   logic                   d_mem_ack;

   logic [`MEM_DATA_W-1:0] arb_rdata;   // to both caches

   // arbiter to backing memory
   logic                   mem_req;
   mem_op_t                mem_op;
   logic [`MEM_ADDR_W-1:0] mem_addr;
   logic [`MEM_DATA_W-1:0] mem_wdata;
   logic                   mem_ack;
   logic [`MEM_DATA_W-1:0] mem_rdata;

   icache icache_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_fetch_en   (i_fetch_en),
      .i_fetch_addr (i_fetch_addr),
      .o_instr      (o_instr),
      .o_i_busy     (o_i_busy),
      .o_mem_req    (i_mem_req),
      .o_mem_addr   (i_mem_addr),
      .i_mem_ack    (i_mem_ack),
      .i_mem_rdata  (arb_rdata)
   );

   dcache dcache_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_d_rd_en   (i_d_rd_en),
      .i_d_wr_en   (i_d_wr_en),
      .i_d_addr    (i_d_addr),
      .i_d_wdata   (i_d_wdata),
      .o_d_rdata   (o_d_rdata),
      .o_d_busy    (o_d_busy),
      .o_mem_req   (d_mem_req),
      .o_mem_op    (d_mem_op),
      .o_mem_addr  (d_mem_addr),
      .o_mem_wdata (d_mem_wdata),
      .i_mem_ack   (d_mem_ack),
      .i_mem_rdata (arb_rdata)
   );

   mem_arbiter mem_arbiter_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_i_req     (i_mem_req),
      .i_i_addr    (i_mem_addr),
      .o_i_ack     (i_mem_ack),
      .i_d_req     (d_mem_req),
      .i_d_op      (d_mem_op),
      .i_d_addr    (d_mem_addr),
      .i_d_wdata   (d_mem_wdata),
      .o_d_ack     (d_mem_ack),
      .o_rdata     (arb_rdata),
      .o_mem_req   (mem_req),
      .o_mem_op    (mem_op),
      .o_mem_addr  (mem_addr),
      .o_mem_wdata (mem_wdata),
      .i_mem_ack   (mem_ack),
      .i_mem_rdata (mem_rdata)
   );

   multicycle_memory multicycle_memory_inst (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_mem_req   (mem_req),
      .i_mem_op    (mem_op),
      .i_mem_addr  (mem_addr),
      .i_mem_wdata (mem_wdata),
      .o_mem_ack   (mem_ack),
      .o_mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

//--- dv/memory_checker.sv
`default_nettype none

`include "mem_defs.svh"

module memory_checker (
   input  wire                   clk,
   input  wire                   i_rst_n,
   input  wire                   i_fetch_en,
   input  wire [`MEM_ADDR_W-1:0] i_fetch_addr,
   input  wire [`MEM_DATA_W-1:0] i_instr,
   input  wire                   i_i_busy,
   input  wire                   i_d_rd_en,
   input  wire                   i_d_wr_en,
   input  wire [`MEM_ADDR_W-1:0] i_d_addr,
   input  wire [`MEM_DATA_W-1:0] i_d_wdata,
   input  wire [`MEM_DATA_W-1:0] i_d_rdata,
   input  wire                   i_d_busy,
   output int                    o_checks,
   output int                    o_errors
);
   timeunit 1ns;
   timeprecision 100ps;

   // every completed write lands here
   logic [`MEM_DATA_W-1:0] shadow [1 << `MEM_ADDR_W];

   initial begin
      o_checks = 0;
      o_errors = 0;
   end

   function automatic logic [`MEM_DATA_W-1:0] expected_word(input logic [`MEM_ADDR_W-1:0] addr);
      return shadow[addr];
   endfunction

   task automatic compare(input string name, input logic [`MEM_DATA_W-1:0] exp_val,
                          input logic [`MEM_DATA_W-1:0] got_val);
      o_checks++;
      if (got_val !== exp_val) begin
         o_errors++;
         $display("** Error at %0d ns: %s expected %0h observed %0h",
                  $time, name, exp_val, got_val);
      end
   endtask

   // sampled at the rising edge, inputs only move on the falling one
   always @(posedge clk) begin
      if (i_rst_n) begin
         if (!i_fetch_en) begin
            compare("o_i_busy", '0, {15'd0, i_i_busy});   // idle side never busy
         end
         if (!i_d_rd_en && !i_d_wr_en) begin
            compare("o_d_busy", '0, {15'd0, i_d_busy});
         end
         if (i_fetch_en && !i_i_busy) begin
            compare("o_instr", expected_word(i_fetch_addr), i_instr);
         end
         if (i_d_rd_en && !i_d_busy) begin
            compare("o_d_rdata", expected_word(i_d_addr), i_d_rdata);
         end
         if (i_d_wr_en && !i_d_busy) begin
            shadow[i_d_addr] = i_d_wdata;   // after the reads of this edge
         end
      end
   end

endmodule

`default_nettype wire

//--- dv/memory_assertions.sv
`default_nettype none

`include "mem_defs.svh"

module memory_assertions (
   input wire clk,
   input wire i_rst_n,
   input wire i_mem_req,
   input wire i_mem_ack
);
   timeunit 1ns;
   timeprecision 100ps;

   ack_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_mem_ack) |-> i_mem_req)
      else $error("memory ack rose with no request pending");

   // requester may not give up before the transfer is acknowledged
   req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_req && !i_mem_ack |=> i_mem_req)
      else $error("memory req dropped before ack");

   ack_after_release: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(i_mem_ack) |-> $past(!i_mem_req))
      else $error("memory ack fell while req was still high");

   ack_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
      $rose(i_mem_req) |-> ##`MEM_LATENCY $rose(i_mem_ack))
      else $error("memory ack did not rise exactly MEM_LATENCY cycles after req");

endmodule

bind multicycle_memory memory_assertions memory_assertions_inst (
   .clk       (clk),
   .i_rst_n   (i_rst_n),
   .i_mem_req (i_mem_req),
   .i_mem_ack (o_mem_ack)
);

`default_nettype wire

//--- dv/memory_tb.sv
`default_nettype none

`include "mem_defs.svh"

module memory_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // accesses issued over all tests
   localparam int OPS   = 86;
   localparam int LIMIT = OPS * (`MEM_LATENCY + 8) * 2 + 100;

   logic                   clk = 1'b0;
   logic                   i_rst_n;
   logic                   i_fetch_en;
   logic [`MEM_ADDR_W-1:0] i_fetch_addr;
   logic [`MEM_DATA_W-1:0] o_instr;
   logic                   o_i_busy;
   logic                   i_d_rd_en;
   logic                   i_d_wr_en;
   logic [`MEM_ADDR_W-1:0] i_d_addr;
   logic [`MEM_DATA_W-1:0] i_d_wdata;
   logic [`MEM_DATA_W-1:0] o_d_rdata;
   logic                   o_d_busy;

   int checks;
   int chk_errors;
   int own_errors;
   int err_mark;
   int test_num;
   int waits;
   int fetch_waits;
   int data_waits;
   logic [31:0]            lcg_state;
   logic [15:0]            r;
   logic [15:0]            t;
   logic [`MEM_ADDR_W-1:0] iaddr [12];   // each written exactly once
   logic [`MEM_ADDR_W-1:0] daddr [8];
   logic [`MEM_ADDR_W-1:0] xaddr [4];

   memory memory_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_fetch_en   (i_fetch_en),
      .i_fetch_addr (i_fetch_addr),
      .o_instr      (o_instr),
      .o_i_busy     (o_i_busy),
      .i_d_rd_en    (i_d_rd_en),
      .i_d_wr_en    (i_d_wr_en),
      .i_d_addr     (i_d_addr),
      .i_d_wdata    (i_d_wdata),
      .o_d_rdata    (o_d_rdata),
      .o_d_busy     (o_d_busy)
   );

   memory_checker memory_checker_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_fetch_en   (i_fetch_en),
      .i_fetch_addr (i_fetch_addr),
      .i_instr      (o_instr),
      .i_i_busy     (o_i_busy),
      .i_d_rd_en    (i_d_rd_en),
      .i_d_wr_en    (i_d_wr_en),
      .i_d_addr     (i_d_addr),
      .i_d_wdata    (i_d_wdata),
      .i_d_rdata    (o_d_rdata),
      .i_d_busy     (o_d_busy),
      .o_checks     (checks),
      .o_errors     (chk_errors)
   );

   always #2 clk = ~clk;

   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];
   endfunction

   // data side lives in the lower half of the address space
   function automatic logic [`MEM_ADDR_W-1:0] data_addr();
      logic [15:0] v;
      v = next_rand();
      return {1'b0, v[14:0]};
   endfunction

   task automatic do_fetch(input logic [`MEM_ADDR_W-1:0] addr, output int n);
      @(negedge clk);
      i_fetch_en   = 1'b1;
      i_fetch_addr = addr;
      n = 0;
      @(posedge clk);
      while (o_i_busy) begin
         n++;
         @(posedge clk);
      end
      @(negedge clk);
      i_fetch_en = 1'b0;
   endtask

   task automatic data_access(input logic wr, input logic [`MEM_ADDR_W-1:0] addr,
                              input logic [`MEM_DATA_W-1:0] wdata, output int n);
      @(negedge clk);
      i_d_wr_en = wr;
      i_d_rd_en = !wr;
      i_d_addr  = addr;
      i_d_wdata = wdata;
      n = 0;
      @(posedge clk);
      while (o_d_busy) begin
         n++;
         @(posedge clk);
      end
      @(negedge clk);
      i_d_wr_en = 1'b0;
      i_d_rd_en = 1'b0;
   endtask

   task automatic expect_hit(input logic [`MEM_ADDR_W-1:0] addr, input int n);
      if (n != 0) begin
         own_errors++;
         $display("read of %h at %0d ns waited %0d cycles, a cache hit was expected",
                  addr, $time, n);
      end
   endtask

   task automatic expect_miss(input logic [`MEM_ADDR_W-1:0] addr, input int n);
      if (n == 0) begin
         own_errors++;
         $display("access to %h at %0d ns completed at once, a cache miss was expected",
                  addr, $time);
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = chk_errors + own_errors - err_mark;
      test_num++;
      if (errs == 0) begin
         $display("test %0d %s: ok", test_num, name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, name, errs);
      end
      err_mark = chk_errors + own_errors;
   endtask

   initial begin
      i_rst_n      = 1'b0;
      i_fetch_en   = 1'b0;
      i_fetch_addr = '0;
      i_d_rd_en    = 1'b0;
      i_d_wr_en    = 1'b0;
      i_d_addr     = '0;
      i_d_wdata    = '0;
      lcg_state    = 32'd30331;
      own_errors   = 0;
      err_mark     = 0;
      test_num     = 0;
      repeat (5) @(negedge clk);
      i_rst_n = 1'b1;

      repeat (10) @(posedge clk);   // checker flags any stray busy
      end_test("idle after reset");

      for (int k = 0; k < 8; k++) begin
         daddr[k] = data_addr();
         data_access(1'b1, daddr[k], next_rand(), waits);
      end
      for (int k = 0; k < 8; k++) begin
         data_access(1'b0, daddr[k], '0, waits);   // miss
         expect_miss(daddr[k], waits);
         data_access(1'b0, daddr[k], '0, waits);
         expect_hit(daddr[k], waits);
      end
      end_test("data write then read");

      // low bits carry k so every instruction address is distinct
      for (int k = 0; k < 12; k++) begin
         r = next_rand();
         iaddr[k] = {1'b1, r[14:5], k[4:0]};
      end
      for (int k = 0; k < 6; k++) begin
         data_access(1'b1, iaddr[k], next_rand(), waits);
      end
      for (int rep = 0; rep < 2; rep++) begin
         for (int k = 0; k < 6; k++) begin
            do_fetch(iaddr[k], waits);
         end
      end
      end_test("fetch preloaded words");

      for (int k = 6; k < 12; k++) begin
         data_access(1'b1, iaddr[k], next_rand(), waits);
      end
      for (int k = 0; k < 4; k++) begin
         xaddr[k] = data_addr();
      end
      fork
         begin
            for (int k = 6; k < 12; k++) begin
               do_fetch(iaddr[k], fetch_waits);
               expect_miss(iaddr[k], fetch_waits);
            end
         end
         begin
            for (int k = 0; k < 4; k++) begin
               data_access(1'b1, xaddr[k], next_rand(), data_waits);
            end
            for (int k = 0; k < 4; k++) begin
               data_access(1'b0, xaddr[k], '0, data_waits);
               expect_miss(xaddr[k], data_waits);   // writes never allocate
            end
         end
      join
      end_test("concurrent fetch and data");

      r = next_rand();   // shared index
      for (int k = 0; k < 4; k++) begin
         t = next_rand();
         xaddr[k] = {1'b0, t[14:6], k[1:0], r[3:0]};
         data_access(1'b1, xaddr[k], next_rand(), waits);
      end
      for (int rep = 0; rep < 2; rep++) begin
         for (int k = 0; k < 4; k++) begin
            data_access(1'b0, xaddr[k], '0, waits);
         end
      end
      end_test("index conflict eviction");

      for (int k = 0; k < 4; k++) begin
         data_access(1'b0, daddr[k], '0, waits);   // make sure the line is cached
         data_access(1'b1, daddr[k], next_rand(), waits);
         data_access(1'b0, daddr[k], '0, waits);
         expect_hit(daddr[k], waits);
      end
      end_test("write hit update");

      $display("%0d tests, %0d checks, %0d errors", test_num, checks,
               chk_errors + own_errors);
      if (chk_errors + own_errors == 0 && checks > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      repeat (LIMIT) @(posedge clk);
      $display("run timed out after %0d cycles, an access never completed", LIMIT);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/mem_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/multicycle_memory.sv
logic/memory.sv
dv/memory_checker.sv
dv/memory_assertions.sv
dv/memory_tb.sv
